// File: qmc_pkg.sv
`default_nettype none

package qmc_pkg;

    // Bits in a Sobol index and in a point word
    localparam int FP_WIDTH = 16;

    // Time-step dimensions per path
    localparam int NUM_DIMS = 4;

    // Dimension number width
    localparam int DIM_W = $clog2(NUM_DIMS);

    // Depth of the XOR reduction tree in the point stage.
    // FP_WIDTH has to be a power of two so the tree has exactly FP_WIDTH leaves
    localparam int XOR_LEVELS = $clog2(FP_WIDTH);

    // Direction ROM size in dimension-major then bit-position order
    localparam int ROM_DEPTH = NUM_DIMS * FP_WIDTH;

endpackage

`default_nettype wire

// File: sobol_index_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sobol_index_sequencer
    import qmc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [FP_WIDTH-1:0] num_paths,
    output logic                busy,
    output logic                seq_valid,
    input  logic                seq_ready,
    output logic [FP_WIDTH-1:0] seq_idx,
    output logic [DIM_W-1:0]    seq_dim,
    output logic                seq_last
);

    logic [FP_WIDTH-1:0] path_count;
    logic [FP_WIDTH-1:0] idx_q;
    logic [DIM_W-1:0]    dim_q;
    logic                launch;
    logic                xfer;
    logic                dim_wrap;

    // A zero path count never starts a run
    assign launch   = start && !busy && (num_paths != '0);
    assign xfer     = seq_valid && seq_ready;
    assign dim_wrap = (dim_q == DIM_W'(NUM_DIMS - 1));

    assign seq_valid = busy;
    assign seq_idx   = idx_q;
    assign seq_dim   = dim_q;
    assign seq_last  = dim_wrap && (idx_q == path_count);

    // Path count is sampled once per run
    always_ff @(posedge clk) begin
        if (launch) begin
            path_count <= num_paths;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            idx_q <= '0;
            dim_q <= '0;
        end else if (launch) begin
            // Sobol index 0 is the origin, so runs start at 1
            busy  <= 1'b1;
            idx_q <= FP_WIDTH'(1);
            dim_q <= '0;
        end else if (xfer) begin
            if (seq_last) begin
                busy <= 1'b0;
            end else if (dim_wrap) begin
                dim_q <= '0;
                idx_q <= idx_q + 1'b1;
            end else begin
                dim_q <= dim_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sobol_point.sv
`timescale 1ns/1ps
`default_nettype none

module sobol_point
    import qmc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    output logic                ready_out,
    output logic                valid_out,
    input  logic                ready_in,
    input  logic [FP_WIDTH-1:0] idx_in,
    input  logic [DIM_W-1:0]    dim_in,
    output logic [FP_WIDTH-1:0] sobol_out
);

    // Direction numbers, one word per (dimension, bit) pair
    logic [FP_WIDTH-1:0] dir_rom [ROM_DEPTH];
    initial $readmemh("direction.mem", dir_rom);

    logic [FP_WIDTH-1:0] gray;
    logic [FP_WIDTH-1:0] sobol_raw;

    // Heap-ordered tree where node i has children 2i+1 and 2i+2
    logic [FP_WIDTH-1:0] node [2*FP_WIDTH-1];

    logic                buf_valid;
    logic [FP_WIDTH-1:0] buf_data;
    logic                accept;
    logic                consume;

    // Gray code lets consecutive indices differ in a single direction word
    assign gray = idx_in ^ (idx_in >> 1);

    // Leaves sit at the bottom of the heap
    for (genvar k = 0; k < FP_WIDTH; k++) begin : g_leaf
        assign node[FP_WIDTH-1+k] = gray[k] ? dir_rom[{dim_in, XOR_LEVELS'(k)}] : '0;
    end

    for (genvar lvl = 0; lvl < XOR_LEVELS; lvl++) begin : g_level
        for (genvar j = 0; j < (1 << lvl); j++) begin : g_pair
            localparam int N = (1 << lvl) - 1 + j;
            assign node[N] = node[2*N+1] ^ node[2*N+2];
        end
    end

    assign sobol_raw = node[0];

    // One-entry output buffer
    assign accept    = valid_in && ready_out;
    assign consume   = buf_valid && ready_in;
    assign ready_out = !buf_valid || ready_in;
    assign valid_out = buf_valid;
    assign sobol_out = buf_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else begin
            case ({accept, consume})
                2'b01:   buf_valid <= 1'b0;
                2'b10:   buf_valid <= 1'b1;
                // Idle, or one in and one out at once
                default: buf_valid <= buf_valid;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_data <= sobol_raw;
        end
    end

endmodule

`default_nettype wire

// File: sobol_digital_shift.sv
`timescale 1ns/1ps
`default_nettype none

module sobol_digital_shift
    import qmc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                shift_load,
    input  logic [DIM_W-1:0]    shift_dim,
    input  logic [FP_WIDTH-1:0] shift_word,
    input  logic                valid_in,
    output logic                ready_out,
    output logic                valid_out,
    input  logic                ready_in,
    input  logic [FP_WIDTH-1:0] point_in,
    input  logic [DIM_W-1:0]    dim_in,
    input  logic                last_in,
    output logic [FP_WIDTH-1:0] point_out,
    output logic [DIM_W-1:0]    dim_out,
    output logic                last_out
);

    // Random shift per dimension as written by the host
    logic [FP_WIDTH-1:0] shift_reg [NUM_DIMS];

    logic out_valid_q;
    logic accept;

    assign accept    = valid_in && ready_out;
    assign ready_out = !out_valid_q || ready_in;
    assign valid_out = out_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < NUM_DIMS; d++) begin
                shift_reg[d] <= '0;
            end
        end else if (shift_load) begin
            shift_reg[shift_dim] <= shift_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (ready_in) begin
            out_valid_q <= 1'b0;
        end
    end

    // Item picks up the shift word as it stood before this edge
    always_ff @(posedge clk) begin
        if (accept) begin
            point_out <= point_in ^ shift_reg[dim_in];
            dim_out   <= dim_in;
            last_out  <= last_in;
        end
    end

endmodule

`default_nettype wire

// File: sobol_qmc_top.sv
`timescale 1ns/1ps
`default_nettype none

module sobol_qmc_top
    import qmc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [FP_WIDTH-1:0] num_paths,
    output logic                busy,
    input  logic                shift_load,
    input  logic [DIM_W-1:0]    shift_dim,
    input  logic [FP_WIDTH-1:0] shift_word,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [FP_WIDTH-1:0] out_data,
    output logic [DIM_W-1:0]    out_dim,
    output logic                out_last
);

    logic                seq_valid;
    logic                seq_ready;
    logic [FP_WIDTH-1:0] seq_idx;
    logic [DIM_W-1:0]    seq_dim;
    logic                seq_last;

    logic                pt_valid;
    logic                pt_ready;
    logic [FP_WIDTH-1:0] pt_data;
    logic [DIM_W-1:0]    pt_dim;
    logic                pt_last;

    sobol_index_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .num_paths (num_paths),
        .busy      (busy),
        .seq_valid (seq_valid),
        .seq_ready (seq_ready),
        .seq_idx   (seq_idx),
        .seq_dim   (seq_dim),
        .seq_last  (seq_last)
    );

    sobol_point u_point (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (seq_valid),
        .ready_out (seq_ready),
        .valid_out (pt_valid),
        .ready_in  (pt_ready),
        .idx_in    (seq_idx),
        .dim_in    (seq_dim),
        .sobol_out (pt_data)
    );

    // Sideband travels beside the point buffer and loads on the same accept
    always_ff @(posedge clk) begin
        if (seq_valid && seq_ready) begin
            pt_dim  <= seq_dim;
            pt_last <= seq_last;
        end
    end

    sobol_digital_shift u_shift (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_load (shift_load),
        .shift_dim  (shift_dim),
        .shift_word (shift_word),
        .valid_in   (pt_valid),
        .ready_out  (pt_ready),
        .valid_out  (out_valid),
        .ready_in   (out_ready),
        .point_in   (pt_data),
        .dim_in     (pt_dim),
        .last_in    (pt_last),
        .point_out  (out_data),
        .dim_out    (out_dim),
        .last_out   (out_last)
    );

endmodule

`default_nettype wire

// File: sobol_qmc_props.sv
`timescale 1ns/1ps
`default_nettype none

module sobol_qmc_props
    import qmc_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                valid_in,
    input logic                ready_out,
    input logic                valid_out,
    input logic                ready_in,
    input logic [DIM_W-1:0]    dim_in,
    input logic [FP_WIDTH-1:0] sobol_out
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;
    logic        seen_accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_accept <= 1'b0;
        end else if (valid_in && ready_out) begin
            seen_accept <= 1'b1;
        end
    end

    // A stalled buffer keeps its valid and its word
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_in |=> valid_out && $stable(sobol_out))
    else begin
        fail_count++;
        $error("point stage output changed while stalled");
    end

    // Nothing leaves the buffer before the first accept
    assert property (@(posedge clk) disable iff (!rst_n)
        !seen_accept |-> !valid_out)
    else begin
        fail_count++;
        $error("point stage valid without an accepted item");
    end

    // An offered dimension is a known number inside the table
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_in |-> !$isunknown(dim_in) && ({1'b0, dim_in} < (DIM_W + 1)'(NUM_DIMS)))
    else begin
        fail_count++;
        $error("point stage dimension out of range");
    end

endmodule

bind sobol_point sobol_qmc_props u_props (.*);

`default_nettype wire

// File: tb_sobol_qmc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sobol_qmc
    import qmc_pkg::*;
();

    localparam int TOTAL_ITEMS = 35 * NUM_DIMS;
    // About 3 cycles per item at worst plus idle gaps with a fourfold margin
    localparam int MAX_CYCLES  = 4 * (3 * TOTAL_ITEMS + 80);

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    logic [FP_WIDTH-1:0] num_paths;
    logic                busy;
    logic                shift_load;
    logic [DIM_W-1:0]    shift_dim;
    logic [FP_WIDTH-1:0] shift_word;
    logic                out_valid;
    logic                out_ready;
    logic [FP_WIDTH-1:0] out_data;
    logic [DIM_W-1:0]    out_dim;
    logic                out_last;

    logic [FP_WIDTH-1:0] ref_rom [ROM_DEPTH];
    logic [FP_WIDTH-1:0] shift_model [NUM_DIMS];
    integer              seed = 32'h0fe9_bc92;
    bit                  random_ready = 1'b0;
    int                  cycles = 0;
    string               test_name = "reset";

    // Scoreboard position in the current run
    int                  sb_paths = 0;
    int                  sb_count = 0;
    logic [FP_WIDTH-1:0] sb_idx = 1;
    logic [DIM_W-1:0]    sb_dim = '0;

    sobol_qmc_top dut (.*);

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string what, input logic [FP_WIDTH-1:0] exp,
                              input logic [FP_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_dim(input string what, input logic [DIM_W-1:0] exp,
                             input logic [DIM_W-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s: %s expected %0d actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s: %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // Gray-code Sobol point plus the digital shift of its dimension
    function automatic logic [FP_WIDTH-1:0] expected_point(input logic [FP_WIDTH-1:0] idx,
                                                           input logic [DIM_W-1:0] dim);
        logic [FP_WIDTH-1:0] gray;
        logic [FP_WIDTH-1:0] acc;
        gray = idx ^ (idx >> 1);
        acc  = shift_model[dim];
        for (int k = 0; k < FP_WIDTH; k++) begin
            if (gray[k]) begin
                acc ^= ref_rom[int'(dim) * FP_WIDTH + k];
            end
        end
        return acc;
    endfunction

    task automatic load_shift(input logic [DIM_W-1:0] dim, input logic [FP_WIDTH-1:0] word);
        @(posedge clk);
        #2;
        shift_load       = 1'b1;
        shift_dim        = dim;
        shift_word       = word;
        shift_model[dim] = word;
        @(posedge clk);
        #2;
        shift_load = 1'b0;
    endtask

    task automatic run_paths(input string name, input int n, input bit check_latency,
                             input bit extra_start);
        test_name = name;
        @(posedge clk);
        #2;
        sb_paths  = n;
        sb_count  = 0;
        sb_idx    = 1;
        sb_dim    = '0;
        num_paths = FP_WIDTH'(n);
        start     = 1'b1;
        @(negedge clk);
        if (check_latency) begin
            check_flag("out_valid before start", 1'b0, out_valid);
        end
        @(posedge clk);
        #2;
        start = 1'b0;
        // Start was seen at the edge just passed and each stage adds a cycle
        if (check_latency) begin
            repeat (2) begin
                @(negedge clk);
                check_flag("out_valid too early", 1'b0, out_valid);
            end
            @(negedge clk);
            check_flag("first item latency", 1'b1, out_valid);
        end
        if (extra_start) begin
            repeat (3) @(posedge clk);
            #2;
            num_paths = FP_WIDTH'(n + 5);
            start     = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (sb_count < n * NUM_DIMS) @(posedge clk);
        // No trailing item and the sequencer idle
        repeat (6) begin
            @(negedge clk);
            check_flag("out_valid after run", 1'b0, out_valid);
            check_flag("busy after run", 1'b0, busy);
        end
    endtask

    always @(posedge clk) begin
        #2;
        if (random_ready) begin
            out_ready = ($unsigned($random(seed)) % 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: no end after %0d cycles, the run hung", MAX_CYCLES);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (sb_count >= sb_paths * NUM_DIMS) begin
                $display("Extra output item after the end of the run in %s", test_name);
                abort_run();
            end else begin
                check_word("point", expected_point(sb_idx, sb_dim), out_data);
                check_dim("dimension", sb_dim, out_dim);
                check_flag("last", (int'(sb_idx) == sb_paths) &&
                           (sb_dim == DIM_W'(NUM_DIMS - 1)), out_last);
                sb_count++;
                if (sb_dim == DIM_W'(NUM_DIMS - 1)) begin
                    sb_dim = '0;
                    sb_idx++;
                end else begin
                    sb_dim++;
                end
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        num_paths  = '0;
        shift_load = 1'b0;
        shift_dim  = '0;
        shift_word = '0;
        out_ready  = 1'b0;
        for (int d = 0; d < NUM_DIMS; d++) begin
            shift_model[d] = '0;
        end
        $readmemh("direction.mem", ref_rom);
        // Every ROM word has to come from the file
        for (int a = 0; a < ROM_DEPTH; a++) begin
            if ($isunknown(ref_rom[a])) begin
                $display("direction.mem is missing or holds fewer than %0d words", ROM_DEPTH);
                abort_run();
            end
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet until the first start
        repeat (5) begin
            @(negedge clk);
            check_flag("out_valid after reset", 1'b0, out_valid);
            check_flag("busy after reset", 1'b0, busy);
        end

        run_paths("eight_paths", 8, 1'b1, 1'b0);

        load_shift(DIM_W'(0), 16'h3a5c);
        load_shift(DIM_W'(1), 16'hc0de);
        load_shift(DIM_W'(2), 16'h5f21);
        load_shift(DIM_W'(3), 16'h9b07);
        run_paths("shifted_paths", 12, 1'b0, 1'b0);

        random_ready = 1'b1;
        run_paths("random_backpressure", 8, 1'b0, 1'b0);
        run_paths("restart", 3, 1'b0, 1'b0);
        run_paths("start_while_busy", 4, 1'b0, 1'b1);
        run_paths("zero_paths", 0, 1'b0, 1'b0);

        if (dut.u_point.u_props.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Point stage assertions failed %0d times", dut.u_point.u_props.fail_count);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: direction.mem
// Sobol direction words in hex, dimension 0..3 each with bit positions 0..15
8000
4000
2000
1000
0800
0400
0200
0100
0080
0040
0020
0010
0008
0004
0002
0001
8000
c000
a000
f000
8800
cc00
aa00
ff00
8080
c0c0
a0a0
f0f0
8888
cccc
aaaa
ffff
8000
c000
6000
9000
e800
5c00
8e00
c500
6880
9cc0
ee60
5590
8068
c09c
60ee
9055
8000
c000
2000
5000
f800
7400
a200
9300
d880
2540
59e0
e6d0
7808
b40c
8202
c305

// File: sim.f
qmc_pkg.sv
sobol_index_sequencer.sv
sobol_point.sv
sobol_digital_shift.sv
sobol_qmc_top.sv
sobol_qmc_props.sv
tb_sobol_qmc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sobol_qmc -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_sobol_qmc 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -eq 0 ] && grep -qx "Simulation finished: PASS" <<< "$sim_output"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
